// ==== src/mcu8_cfg.svh ====
`ifndef MCU8_CFG_SVH
`define MCU8_CFG_SVH

// datapath width
`define MCU8_DATA_W    8

// program space, 4k words
`define MCU8_ADDR_W    12

// instruction word, opcode in bits 17..12
`define MCU8_INSTR_W   18
`define MCU8_OPCODE_W  6

// register file, sixteen entries
`define MCU8_REG_AW    4

// call stack, 32 return addresses
`define MCU8_STACK_AW  5

`endif

// ==== src/mcu8_pkg.sv ====
`include "mcu8_cfg.svh"

package mcu8_pkg;

   // register forms; setting bit 0 selects the kk / pp form
   typedef enum logic [`MCU8_OPCODE_W-1:0] {
      op_load      = 6'b000000,
      op_and       = 6'b000010,
      op_or        = 6'b000100,
      op_xor       = 6'b000110,
      op_input     = 6'b001000,
      op_add       = 6'b010000,
      op_addcy     = 6'b010010,
      op_sub       = 6'b011000,
      op_subcy     = 6'b011010,
      op_compare   = 6'b011100,
      op_comparecy = 6'b011110,
      op_output    = 6'b101100,
      op_call      = 6'b100000,
      op_jump      = 6'b100010,
      op_return    = 6'b100101,
      op_call_z    = 6'b110000,
      op_jump_z    = 6'b110010,
      op_call_nz   = 6'b110100,
      op_jump_nz   = 6'b110110,
      op_call_c    = 6'b111000,
      op_jump_c    = 6'b111010,
      op_call_nc   = 6'b111100,
      op_jump_nc   = 6'b111110
   } opcode_t;

   typedef struct packed {
      opcode_t                 opcode;
      logic [`MCU8_REG_AW-1:0] sx;
      logic [`MCU8_DATA_W-1:0] low;    // sy in the upper nibble, or kk
   } instr_t;

   typedef enum logic [1:0] {
      br_none,
      br_jump,
      br_call,
      br_return
   } branch_t;

   typedef enum logic [2:0] {
      cond_always,
      cond_z,
      cond_nz,
      cond_c,
      cond_nc
   } cond_t;

   typedef enum logic [3:0] {
      alu_none,
      alu_load,
      alu_and,
      alu_or,
      alu_xor,
      alu_add,
      alu_sub,
      alu_input,
      alu_output
   } alu_op_t;

   typedef struct packed {
      alu_op_t                 alu_op;
      logic                    use_const;
      logic                    use_carry;
      logic                    is_compare;
      branch_t                 branch;
      cond_t                   cond;
      logic [`MCU8_REG_AW-1:0] sx;
      logic [`MCU8_REG_AW-1:0] sy;
      logic [`MCU8_DATA_W-1:0] kk;
      logic [`MCU8_ADDR_W-1:0] target;
   } ctrl_t;

   typedef struct packed {
      logic z;
      logic c;
   } flags_t;

   typedef struct packed {
      logic                    en;
      logic [`MCU8_REG_AW-1:0] addr;
      logic [`MCU8_DATA_W-1:0] data;
   } reg_wr_t;

endpackage

// ==== src/mcu8_decoder.sv ====
`include "mcu8_cfg.svh"

module mcu8_decoder (
   input  mcu8_pkg::instr_t instruction,
   output mcu8_pkg::ctrl_t  ctrl
);
   import mcu8_pkg::*;

   logic [`MCU8_OPCODE_W-1:0] op;

   assign op = instruction.opcode;

   always_comb
   begin
      ctrl            = '0;
      ctrl.alu_op     = alu_none;
      ctrl.branch     = br_none;
      ctrl.cond       = cond_always;
      ctrl.sx         = instruction.sx;
      ctrl.sy         = instruction.low[7:4];
      ctrl.kk         = instruction.low;
      ctrl.target     = {instruction.sx, instruction.low};
      ctrl.use_const  = op[0];

      // datapath group, bit 0 picks kk and bit 1 the carry-in
      casez (op)
         6'b00000?: ctrl.alu_op = alu_load;
         6'b00001?: ctrl.alu_op = alu_and;
         6'b00010?: ctrl.alu_op = alu_or;
         6'b00011?: ctrl.alu_op = alu_xor;
         6'b00100?: ctrl.alu_op = alu_input;
         6'b10110?: ctrl.alu_op = alu_output;
         6'b0100??:
         begin
            ctrl.alu_op    = alu_add;
            ctrl.use_carry = op[1];
         end
         6'b0110??:
         begin
            ctrl.alu_op    = alu_sub;
            ctrl.use_carry = op[1];
         end
         6'b0111??:
         begin
            ctrl.alu_op     = alu_sub;   // compare is a subtract without write-back
            ctrl.use_carry  = op[1];
            ctrl.is_compare = 1'b1;
         end
         default: ;
      endcase

      // program flow group
      case (instruction.opcode)
         op_jump:   ctrl.branch = br_jump;
         op_call:   ctrl.branch = br_call;
         op_return: ctrl.branch = br_return;
         op_jump_z, op_jump_nz, op_jump_c, op_jump_nc:
         begin
            ctrl.branch = br_jump;
            ctrl.cond   = cond_t'({1'b0, op[3:2]} + 3'd1);   // z, nz, c, nc in order
         end
         op_call_z, op_call_nz, op_call_c, op_call_nc:
         begin
            ctrl.branch = br_call;
            ctrl.cond   = cond_t'({1'b0, op[3:2]} + 3'd1);
         end
         default: ;
      endcase
   end

endmodule

// ==== src/mcu8_dpram.sv ====
module mcu8_dpram #(
   parameter type payload_t = logic [7:0],
   parameter int  addr_w    = 4
) (
   input  logic              clk,
   input  logic [addr_w-1:0] wr_addr,
   input  logic              wr_en,
   input  payload_t          wr_data,
   input  logic [addr_w-1:0] rd_addr,
   output payload_t          rd_data
);

   payload_t mem [2**addr_w];

   // contents start at zero
   initial
   begin
      for (int i = 0; i < 2**addr_w; i++)
      begin
         mem[i] = '0;
      end
   end

   always @(posedge clk)
   begin
      if (wr_en)
      begin
         mem[wr_addr] <= wr_data;
      end
   end

   assign rd_data = mem[rd_addr];   // asynchronous read

endmodule

// ==== src/mcu8_alu.sv ====
`include "mcu8_cfg.svh"

module mcu8_alu (
   input  logic                    clk,
   input  logic                    core_rst,
   input  logic                    decode_phase,
   input  logic                    execute_phase,
   input  mcu8_pkg::ctrl_t         ctrl,
   input  logic [`MCU8_DATA_W-1:0] sx_data,
   input  logic [`MCU8_DATA_W-1:0] sy_data,
   input  logic [`MCU8_DATA_W-1:0] in_port,
   output mcu8_pkg::reg_wr_t       reg_wr,
   output mcu8_pkg::flags_t        flags,
   output logic [`MCU8_DATA_W-1:0] port_id,
   output logic [`MCU8_DATA_W-1:0] out_port,
   output logic                    read_strobe,
   output logic                    write_strobe
);
   import mcu8_pkg::*;

   logic [`MCU8_DATA_W-1:0] opnd_b;
   logic                    cin;
   logic [`MCU8_DATA_W:0]   result;      // bit 8 is carry or borrow
   logic [`MCU8_DATA_W:0]   result_q;
   alu_op_t                 op_q;
   logic                    carry_q;
   logic                    compare_q;
   logic [`MCU8_REG_AW-1:0] sx_q;
   logic                    res_zero;
   logic                    writes_sx;

   //////////////////////////////////////////////////
   // decode phase

   assign opnd_b = ctrl.use_const ? ctrl.kk : sy_data;
   assign cin    = ctrl.use_carry & flags.c;

   always_comb
   begin
      case (ctrl.alu_op)
         alu_load:   result = {1'b0, opnd_b};
         alu_and:    result = {1'b0, sx_data & opnd_b};
         alu_or:     result = {1'b0, sx_data | opnd_b};
         alu_xor:    result = {1'b0, sx_data ^ opnd_b};
         alu_add:    result = {1'b0, sx_data} + {1'b0, opnd_b} + {{`MCU8_DATA_W{1'b0}}, cin};
         alu_sub:    result = {1'b0, sx_data} - {1'b0, opnd_b} - {{`MCU8_DATA_W{1'b0}}, cin};
         alu_output: result = {1'b0, sx_data};    // held for out_port
         default:    result = '0;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (core_rst)
      begin
         op_q <= alu_none;
      end
      else if (decode_phase)
      begin
         op_q <= ctrl.alu_op;
      end
   end

   always_ff @(posedge clk)
   begin
      if (decode_phase)
      begin
         result_q  <= result;
         carry_q   <= ctrl.use_carry;
         compare_q <= ctrl.is_compare;
         sx_q      <= ctrl.sx;
      end
   end

   //////////////////////////////////////////////////
   // execute phase

   assign res_zero = (result_q[`MCU8_DATA_W-1:0] == '0);

   always_ff @(posedge clk)
   begin
      if (core_rst)
      begin
         flags <= '0;
      end
      else if (execute_phase)
      begin
         case (op_q)
            alu_and, alu_or, alu_xor:
            begin
               flags.z <= res_zero;
               flags.c <= 1'b0;
            end
            alu_add, alu_sub:
            begin
               flags.z <= res_zero & (~carry_q | flags.z);   // chained forms keep Z
               flags.c <= result_q[`MCU8_DATA_W];
            end
            default: ;   // both flags hold
         endcase
      end
   end

   assign writes_sx = (op_q inside {alu_load, alu_and, alu_or, alu_xor, alu_add, alu_sub,
                                    alu_input}) & ~compare_q;

   always_comb
   begin
      reg_wr.en   = execute_phase & writes_sx;
      reg_wr.addr = sx_q;
      reg_wr.data = (op_q == alu_input) ? in_port : result_q[`MCU8_DATA_W-1:0];
   end

   // port strobes
   assign port_id      = opnd_b;   // instruction is held through execute
   assign out_port     = result_q[`MCU8_DATA_W-1:0];
   assign read_strobe  = decode_phase & (ctrl.alu_op == alu_input);
   assign write_strobe = execute_phase & (op_q == alu_output);

endmodule

// ==== src/mcu8_sequencer.sv ====
`include "mcu8_cfg.svh"

module mcu8_sequencer (
   input  logic                    clk,
   input  logic                    rst,
   input  mcu8_pkg::ctrl_t         ctrl,
   input  mcu8_pkg::flags_t        flags,
   output logic [`MCU8_ADDR_W-1:0] address,
   output logic                    bram_enable,
   output logic                    decode_phase,
   output logic                    execute_phase,
   output logic                    core_rst
);
   import mcu8_pkg::*;

   logic                      rst_meta;
   logic                      rst_sync;
   logic                      stack_fault;   // one-cycle restart request
   logic [`MCU8_ADDR_W-1:0]   pc;
   logic [`MCU8_ADDR_W-1:0]   pc_next;
   logic [`MCU8_STACK_AW:0]   sp;            // entries stacked, 0 to 32
   logic [`MCU8_STACK_AW-1:0] top_addr;
   logic [`MCU8_ADDR_W-1:0]   pop_addr;
   logic                      taken;
   logic                      push;
   logic                      pop;
   logic                      fault;

   //////////////////////////////////////////////////
   // reset

   always_ff @(posedge clk)
   begin
      rst_meta <= rst;
      rst_sync <= rst_meta;
   end

   assign core_rst = rst_sync | stack_fault;

   //////////////////////////////////////////////////
   // branch decision and stack

   always_comb
   begin
      case (ctrl.cond)
         cond_z:  taken = flags.z;
         cond_nz: taken = ~flags.z;
         cond_c:  taken = flags.c;
         cond_nc: taken = ~flags.c;
         default: taken = 1'b1;
      endcase
   end

   assign push     = decode_phase & (ctrl.branch == br_call) & taken;
   assign pop      = decode_phase & (ctrl.branch == br_return);
   assign fault    = (push & sp[`MCU8_STACK_AW]) | (pop & (sp == '0));   // msb set means full
   assign pc_next  = pc + 1'b1;
   assign top_addr = sp[`MCU8_STACK_AW-1:0] - 1'b1;

   mcu8_dpram #(
      .payload_t (logic [`MCU8_ADDR_W-1:0]),
      .addr_w    (`MCU8_STACK_AW)
   ) u_stack (
      .clk     (clk),
      .wr_addr (sp[`MCU8_STACK_AW-1:0]),
      .wr_en   (push & ~fault),
      .wr_data (pc_next),
      .rd_addr (top_addr),
      .rd_data (pop_addr)
   );

   //////////////////////////////////////////////////
   // phases and program counter

   always_ff @(posedge clk)
   begin
      if (core_rst)
      begin
         bram_enable   <= 1'b0;
         decode_phase  <= 1'b0;
         execute_phase <= 1'b0;
         stack_fault   <= 1'b0;
         pc            <= '0;
         sp            <= '0;
      end
      else
      begin
         bram_enable   <= ~bram_enable & ~fault;   // no fetch on the way to a restart
         decode_phase  <= bram_enable;
         execute_phase <= decode_phase;
         stack_fault   <= fault;
         if (decode_phase & ~fault)
         begin
            if (push)
            begin
               pc <= ctrl.target;
               sp <= sp + 1'b1;
            end
            else if (pop)
            begin
               pc <= pop_addr;
               sp <= sp - 1'b1;
            end
            else if ((ctrl.branch == br_jump) & taken)
            begin
               pc <= ctrl.target;
            end
            else
            begin
               pc <= pc_next;
            end
         end
      end
   end

   assign address = pc;

endmodule

// ==== src/mcu8_top.sv ====
`include "mcu8_cfg.svh"

module mcu8_top (
   input  logic                     clk,
   input  logic                     rst,
   input  logic [`MCU8_INSTR_W-1:0] instruction,
   input  logic [`MCU8_DATA_W-1:0]  in_port,
   output logic [`MCU8_ADDR_W-1:0]  address,
   output logic                     bram_enable,
   output logic [`MCU8_DATA_W-1:0]  port_id,
   output logic [`MCU8_DATA_W-1:0]  out_port,
   output logic                     read_strobe,
   output logic                     write_strobe
);
   import mcu8_pkg::*;

   instr_t                  instr;
   ctrl_t                   ctrl;
   flags_t                  flags;
   reg_wr_t                 reg_wr;
   logic                    decode_phase;
   logic                    execute_phase;
   logic                    core_rst;
   logic [`MCU8_DATA_W-1:0] sx_data;
   logic [`MCU8_DATA_W-1:0] sy_data;

   assign instr = instr_t'(instruction);

   mcu8_decoder u_decoder (
      .instruction (instr),
      .ctrl        (ctrl)
   );

   mcu8_sequencer u_sequencer (
      .clk           (clk),
      .rst           (rst),
      .ctrl          (ctrl),
      .flags         (flags),
      .address       (address),
      .bram_enable   (bram_enable),
      .decode_phase  (decode_phase),
      .execute_phase (execute_phase),
      .core_rst      (core_rst)
   );

   mcu8_alu u_alu (
      .clk           (clk),
      .core_rst      (core_rst),
      .decode_phase  (decode_phase),
      .execute_phase (execute_phase),
      .ctrl          (ctrl),
      .sx_data       (sx_data),
      .sy_data       (sy_data),
      .in_port       (in_port),
      .reg_wr        (reg_wr),
      .flags         (flags),
      .port_id       (port_id),
      .out_port      (out_port),
      .read_strobe   (read_strobe),
      .write_strobe  (write_strobe)
   );

   // register file, one copy per read port
   mcu8_dpram #(
      .payload_t (logic [`MCU8_DATA_W-1:0]),
      .addr_w    (`MCU8_REG_AW)
   ) u_regs_sx (
      .clk     (clk),
      .wr_addr (reg_wr.addr),
      .wr_en   (reg_wr.en),
      .wr_data (reg_wr.data),
      .rd_addr (ctrl.sx),
      .rd_data (sx_data)
   );

   mcu8_dpram #(
      .payload_t (logic [`MCU8_DATA_W-1:0]),
      .addr_w    (`MCU8_REG_AW)
   ) u_regs_sy (
      .clk     (clk),
      .wr_addr (reg_wr.addr),
      .wr_en   (reg_wr.en),
      .wr_data (reg_wr.data),
      .rd_addr (ctrl.sy),
      .rd_data (sy_data)
   );

endmodule

// ==== bench/mcu8_properties.sv ====
module mcu8_properties (
   input logic clk,
   input logic bram_enable,
   input logic read_strobe,
   input logic write_strobe
);

   int violations = 0;   // read back by the testbench summary

   // a port access is either a read or a write
   one_strobe: assert property (@(posedge clk) !(read_strobe && write_strobe))
   else
   begin
      violations++;
      $error("read_strobe and write_strobe high in the same cycle");
   end

   single_write: assert property (@(posedge clk) write_strobe |=> !write_strobe)
   else
   begin
      violations++;
      $error("write_strobe held for more than one cycle");
   end

   // fetches alternate with decode cycles
   fetch_gap: assert property (@(posedge clk) bram_enable |=> !bram_enable)
   else
   begin
      violations++;
      $error("bram_enable high on two consecutive cycles");
   end

endmodule

bind mcu8_top mcu8_properties u_props (
   .clk          (clk),
   .bram_enable  (bram_enable),
   .read_strobe  (read_strobe),
   .write_strobe (write_strobe)
);

// ==== bench/mcu8_tb.sv ====
`include "mcu8_cfg.svh"

module mcu8_tb;
   import mcu8_pkg::*;

   localparam int NUM_RUNS    = 11;
   localparam int CYCLE_LIMIT = NUM_RUNS * 400 + 200;
   localparam int STACK_DEPTH = 2 ** `MCU8_STACK_AW;

   logic                     clk;
   logic                     rst;
   logic [`MCU8_INSTR_W-1:0] instruction;
   logic [`MCU8_DATA_W-1:0]  in_port;
   logic [`MCU8_ADDR_W-1:0]  address;
   logic                     bram_enable;
   logic [`MCU8_DATA_W-1:0]  port_id;
   logic [`MCU8_DATA_W-1:0]  out_port;
   logic                     read_strobe;
   logic                     write_strobe;

   logic [`MCU8_INSTR_W-1:0] prog [2**`MCU8_ADDR_W];
   logic [`MCU8_DATA_W-1:0]  wr_port [$];
   logic [`MCU8_DATA_W-1:0]  wr_data [$];
   logic [`MCU8_ADDR_W-1:0]  fetches [$];
   int                       emit_at  = 0;
   int                       strobes  = 0;
   int                       cycles   = 0;
   int                       n_checks = 0;
   int                       n_errors = 0;
   int                       seed;

   mcu8_top DUT (
      .clk          (clk),
      .rst          (rst),
      .instruction  (instruction),
      .in_port      (in_port),
      .address      (address),
      .bram_enable  (bram_enable),
      .port_id      (port_id),
      .out_port     (out_port),
      .read_strobe  (read_strobe),
      .write_strobe (write_strobe)
   );

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #10 clk = ~clk;
      end
   end

   //////////////////////////////////////////////////
   // program memory and port model

   always @(posedge clk)
   begin
      if (bram_enable)
      begin
         instruction <= prog[address];   // word shows up on the decode cycle
         fetches.push_back(address);
      end
      if (read_strobe)
      begin
         in_port <= port_id + 8'h30;
      end
      if (write_strobe)
      begin
         wr_port.push_back(port_id);
         wr_data.push_back(out_port);
      end
      if (read_strobe | write_strobe)
      begin
         strobes++;
      end
   end

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT)
      begin
         $display("run hung, cycle limit of %0d reached", CYCLE_LIMIT);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   //////////////////////////////////////////////////
   // assembler and program loading

   function automatic logic [`MCU8_INSTR_W-1:0] const_instr(input opcode_t op,
         input logic [`MCU8_REG_AW-1:0] sx, input logic [`MCU8_DATA_W-1:0] kk);
      logic [`MCU8_OPCODE_W-1:0] code;
      code    = op;
      code[0] = 1'b1;   // kk or pp form
      return {code, sx, kk};
   endfunction

   function automatic logic [`MCU8_INSTR_W-1:0] reg_instr(input opcode_t op,
         input logic [`MCU8_REG_AW-1:0] sx, input logic [`MCU8_REG_AW-1:0] sy);
      return {op, sx, sy, 4'h0};
   endfunction

   function automatic logic [`MCU8_INSTR_W-1:0] flow_instr(input opcode_t op,
         input logic [`MCU8_ADDR_W-1:0] target);
      return {op, target};
   endfunction

   task automatic emit(input logic [`MCU8_INSTR_W-1:0] word);
      prog[emit_at] = word;
      emit_at++;
   endtask

   task automatic clear_program();
      for (int i = 0; i < 2**`MCU8_ADDR_W; i++)
      begin
         prog[i] = flow_instr(op_jump, i[`MCU8_ADDR_W-1:0]);   // spare words spin in place
      end
      emit_at = 0;
   endtask

   task automatic restart();
      @(posedge clk);
      rst <= 1'b1;
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      wr_port.delete();   // core is quiet here
      wr_data.delete();
      fetches.delete();
      strobes = 0;
   endtask

   task automatic wait_writes(input int n_write, input int n_fetch);
      while (wr_data.size() < n_write || fetches.size() < n_fetch)
      begin
         @(negedge clk);
      end
   endtask

   //////////////////////////////////////////////////
   // compare tasks

   task automatic check_data(input string name, input logic [`MCU8_DATA_W-1:0] exp,
         input logic [`MCU8_DATA_W-1:0] act);
      n_checks++;
      if (act !== exp)
      begin
         n_errors++;
         $display("MISMATCH %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_addr(input string name, input logic [`MCU8_ADDR_W-1:0] exp,
         input logic [`MCU8_ADDR_W-1:0] act);
      n_checks++;
      if (act !== exp)
      begin
         n_errors++;
         $display("MISMATCH %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_flags(input string name, input flags_t exp, input flags_t act);
      n_checks++;
      if (act !== exp)
      begin
         n_errors++;
         $display("MISMATCH %s expected z=%b c=%b actual z=%b c=%b", name, exp.z, exp.c,
                  act.z, act.c);
      end
   endtask

   task automatic expect_write(input string name, input int idx,
         input logic [`MCU8_DATA_W-1:0] port, input logic [`MCU8_DATA_W-1:0] data);
      check_data({name, " port"}, port, wr_port[idx]);
      check_data({name, " data"}, data, wr_data[idx]);
   endtask

   //////////////////////////////////////////////////
   // directed tests

   task automatic reset_behavior();
      clear_program();
      emit(const_instr(op_load, 4'd0, 8'hff));
      emit(const_instr(op_output, 4'd0, 8'h70));
      emit(reg_instr(op_load, 4'd1, 4'd0));
      emit(const_instr(op_add, 4'd1, 8'h01));   // ff + 01 sets Z and C
      emit(const_instr(op_output, 4'd1, 8'h71));
      emit(flow_instr(op_jump, 12'h001));
      restart();
      wait_writes(4, 0);   // core busy with strobes, pc away from 0
      check_flags("reset flags before", 2'b11, DUT.u_alu.flags);
      restart();
      wait_writes(0, 1);
      n_checks++;
      if (strobes != 0)
      begin
         n_errors++;
         $display("reset: a port strobe was raised before the first fetch");
      end
      check_addr("reset first fetch", '0, fetches[0]);
      check_flags("reset flags", '0, DUT.u_alu.flags);
   endtask

   task automatic logic_ops();
      logic [`MCU8_DATA_W-1:0] a;
      logic [`MCU8_DATA_W-1:0] b;
      logic [`MCU8_DATA_W-1:0] c;
      flags_t                  f;
      a = 8'($urandom);
      b = 8'($urandom);
      c = 8'($urandom);
      clear_program();
      emit(const_instr(op_load, 4'd0, a));
      emit(const_instr(op_load, 4'd1, b));
      emit(reg_instr(op_load, 4'd2, 4'd0));
      emit(reg_instr(op_and, 4'd2, 4'd1));
      emit(const_instr(op_output, 4'd2, 8'h10));
      emit(reg_instr(op_load, 4'd3, 4'd0));
      emit(const_instr(op_or, 4'd3, c));
      emit(const_instr(op_output, 4'd3, 8'h11));
      emit(reg_instr(op_load, 4'd4, 4'd1));
      emit(reg_instr(op_xor, 4'd4, 4'd0));
      emit(const_instr(op_output, 4'd4, 8'h12));
      emit(const_instr(op_and, 4'd0, c));
      emit(const_instr(op_output, 4'd0, 8'h13));
      emit(reg_instr(op_load, 4'd5, 4'd1));
      emit(const_instr(op_output, 4'd5, 8'h15));
      emit(const_instr(op_xor, 4'd1, c));   // last flag update
      emit(const_instr(op_output, 4'd1, 8'h14));
      restart();
      wait_writes(6, 0);
      expect_write("logic and reg", 0, 8'h10, a & b);
      expect_write("logic or const", 1, 8'h11, a | c);
      expect_write("logic xor reg", 2, 8'h12, b ^ a);
      expect_write("logic and const", 3, 8'h13, a & c);
      expect_write("logic load reg", 4, 8'h15, b);
      expect_write("logic xor const", 5, 8'h14, b ^ c);
      f.z = ((b ^ c) == 8'h00);
      f.c = 1'b0;
      check_flags("logic flags", f, DUT.u_alu.flags);
   endtask

   task automatic carry_chain(input string name, input logic [15:0] x, input logic [15:0] y);
      logic [15:0] sum;
      logic [15:0] diff;
      flags_t      f;
      sum  = x + y;
      diff = x - y;
      clear_program();
      emit(const_instr(op_load, 4'd0, x[7:0]));
      emit(const_instr(op_load, 4'd1, x[15:8]));
      emit(const_instr(op_load, 4'd2, y[7:0]));
      emit(const_instr(op_load, 4'd3, y[15:8]));
      emit(reg_instr(op_load, 4'd4, 4'd0));
      emit(reg_instr(op_add, 4'd4, 4'd2));
      emit(reg_instr(op_load, 4'd5, 4'd1));   // flags ride over the load
      emit(reg_instr(op_addcy, 4'd5, 4'd3));
      emit(const_instr(op_output, 4'd4, 8'h20));
      emit(const_instr(op_output, 4'd5, 8'h21));
      emit(reg_instr(op_load, 4'd6, 4'd0));
      emit(reg_instr(op_sub, 4'd6, 4'd2));
      emit(reg_instr(op_load, 4'd7, 4'd1));
      emit(reg_instr(op_subcy, 4'd7, 4'd3));
      emit(const_instr(op_output, 4'd6, 8'h22));
      emit(const_instr(op_output, 4'd7, 8'h23));
      restart();
      wait_writes(4, 0);
      expect_write({name, " sum lo"}, 0, 8'h20, sum[7:0]);
      expect_write({name, " sum hi"}, 1, 8'h21, sum[15:8]);
      expect_write({name, " diff lo"}, 2, 8'h22, diff[7:0]);
      expect_write({name, " diff hi"}, 3, 8'h23, diff[15:8]);
      f.z = (diff == 16'h0000);
      f.c = (x < y);   // borrow out of the high byte
      check_flags({name, " flags"}, f, DUT.u_alu.flags);
   endtask

   task automatic compare_branch(input string name, input logic [`MCU8_DATA_W-1:0] a,
         input logic [`MCU8_DATA_W-1:0] b);
      logic [`MCU8_DATA_W-1:0] marker;
      if (a < b)
      begin
         marker = 8'hc1;   // borrow sets C
      end
      else if (a == b)
      begin
         marker = 8'he1;
      end
      else
      begin
         marker = 8'ha1;
      end
      clear_program();
      emit(const_instr(op_load, 4'd0, a));
      emit(const_instr(op_compare, 4'd0, b));
      emit(flow_instr(op_jump_c, 12'h006));
      emit(flow_instr(op_jump_z, 12'h008));
      emit(const_instr(op_load, 4'd1, 8'ha1));
      emit(flow_instr(op_jump, 12'h00a));
      emit(const_instr(op_load, 4'd1, 8'hc1));
      emit(flow_instr(op_jump, 12'h00a));
      emit(const_instr(op_load, 4'd1, 8'he1));
      emit(flow_instr(op_jump, 12'h00a));
      emit(const_instr(op_output, 4'd1, 8'h40));
      emit(const_instr(op_output, 4'd0, 8'h41));   // compare leaves s0 alone
      restart();
      wait_writes(2, 0);
      expect_write({name, " marker"}, 0, 8'h40, marker);
      expect_write({name, " operand"}, 1, 8'h41, a);
   endtask

   task automatic input_calls();
      logic [`MCU8_DATA_W-1:0] p;
      logic [`MCU8_ADDR_W-1:0] trace [9];
      p     = 8'($urandom);
      trace = '{12'h000, 12'h001, 12'h100, 12'h200, 12'h300, 12'h201, 12'h101, 12'h002,
                12'h003};
      clear_program();
      emit(const_instr(op_input, 4'd0, p));
      emit(flow_instr(op_call, 12'h100));
      emit(const_instr(op_output, 4'd0, 8'h50));
      emit_at = 'h100;
      emit(flow_instr(op_call, 12'h200));
      emit(flow_instr(op_return, 12'h000));
      emit_at = 'h200;
      emit(flow_instr(op_call, 12'h300));
      emit(flow_instr(op_return, 12'h000));
      emit_at = 'h300;
      emit(flow_instr(op_return, 12'h000));   // deepest level
      restart();
      wait_writes(1, 9);
      expect_write("input after calls", 0, 8'h50, p + 8'h30);
      foreach (trace[i])
      begin
         check_addr($sformatf("call trace fetch %0d", i), trace[i], fetches[i]);
      end
   endtask

   task automatic stack_overflow();
      int zeros;
      int calls;
      zeros = 0;
      calls = 0;
      clear_program();
      emit(const_instr(op_load, 4'd0, 8'h5a));
      emit(const_instr(op_output, 4'd0, 8'h60));
      emit(flow_instr(op_call, 12'h002));   // recurses until the stack is full
      restart();
      wait_writes(2, 0);
      expect_write("overflow first start", 0, 8'h60, 8'h5a);
      expect_write("overflow restart", 1, 8'h60, 8'h5a);
      foreach (fetches[i])
      begin
         if (fetches[i] == '0)
         begin
            zeros++;
         end
         else if (fetches[i] == 12'h002 && zeros == 1)
         begin
            calls++;
         end
      end
      check_data("overflow call fetches", 8'(STACK_DEPTH + 1), 8'(calls));
   endtask

   //////////////////////////////////////////////////
   // main sequence

   initial
   begin
      rst         = 1'b1;
      instruction = '0;
      in_port     = '0;
      seed        = $urandom(32'hda4d);
      reset_behavior();
      logic_ops();
      carry_chain("carry random", 16'($urandom), 16'($urandom));
      carry_chain("carry equal", 16'h8e41, 16'h8e41);
      repeat (2) compare_branch("compare random", 8'($urandom), 8'($urandom));
      compare_branch("compare equal", 8'h5c, 8'h5c);
      compare_branch("compare less", 8'h12, 8'h9f);
      input_calls();
      stack_overflow();
      if (DUT.u_props.violations != 0)
      begin
         $display("%0d assertion failures in the bound properties", DUT.u_props.violations);
         n_errors += DUT.u_props.violations;
      end
      $display("checks %0d, errors %0d", n_checks, n_errors);
      if (n_errors == 0)
      begin
         $display("SIMULATION PASSED");
      end
      else
      begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

// ==== verilog.f ====
+incdir+src
src/mcu8_pkg.sv
src/mcu8_decoder.sv
src/mcu8_dpram.sv
src/mcu8_alu.sv
src/mcu8_sequencer.sv
src/mcu8_top.sv
bench/mcu8_properties.sv
bench/mcu8_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module mcu8_tb \
   -f verilog.f -o mcu8_sim > build.log 2>&1 \
   || { cat build.log; echo "verilator build failed"; exit 1; }
./obj_dir/mcu8_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -qx "SIMULATION PASSED" sim.log && echo "run ok" || { echo "run not ok"; exit 1; }
